// ==== soc_harness.f ====
verilog/soc_pkg.sv
verilog/debug_module.sv
verilog/bus_decoder.sv
verilog/bus_to_mem.sv
verilog/sram.sv
verilog/soc_harness.sv
sim/tb_soc_harness.sv

// ==== sim/tb_soc_harness.sv ====
// --------------------------------------------------------------------------
// Directed testbench for the debug harness with default parameters. The
// memory map below must match MEM_BASE and MEM_WORDS of the DUT.
// --------------------------------------------------------------------------

module tb_soc_harness;
    timeunit 1ns;
    timeprecision 1ps;
    import soc_pkg::*;

    localparam logic [31:0] MEM_BASE  = 32'h8000_0000;
    localparam int          MEM_WORDS = 1024;
    localparam int          SEED      = 37;
    // DMI accesses per test: 5 + 65 + 20 + 17 + 16
    localparam int PLANNED_ACCESSES = 123;
    localparam int WATCHDOG_CYCLES  = 2 * 8 * PLANNED_ACCESSES + 4;

    logic        clk_i;
    logic        rst_i;
    logic        dmi_req_valid_i;
    dmi_req_t    dmi_req_i;
    logic        dmi_rsp_valid_o;
    dmi_rsp_t    dmi_rsp_o;
    logic [31:0] exit_o;

    int    errors;
    int    tests_run;
    int    tests_clean;
    int    errors_at_start;
    string test_name;

    soc_harness dut0 (
        .clk_i           ( clk_i           ),
        .rst_i           ( rst_i           ),
        .dmi_req_valid_i ( dmi_req_valid_i ),
        .dmi_req_i       ( dmi_req_i       ),
        .dmi_rsp_valid_o ( dmi_rsp_valid_o ),
        .dmi_rsp_o       ( dmi_rsp_o       ),
        .exit_o          ( exit_o          )
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // ----------------------------------------------------------------------
    // Compare tasks
    // ----------------------------------------------------------------------
    task automatic check_rsp(input string what, input dmi_rsp_t exp, input dmi_rsp_t act);
        if (act !== exp) begin
            errors++;
            $display("Fail %s (%s): expected resp %0d data %h, actual resp %0d data %h",
                     test_name, what, exp.resp, exp.data, act.resp, act.data);
        end
    endtask

    task automatic check_word(input string what, input logic [31:0] exp,
                              input logic [31:0] act);
        if (act !== exp) begin
            errors++;
            $display("Fail %s (%s): expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_latency(input string what, input int exp, input int act);
        if (act != exp) begin
            errors++;
            $display("Fail %s (%s latency): expected %0d cycles, actual %0d cycles",
                     test_name, what, exp, act);
        end
    endtask

    // ----------------------------------------------------------------------
    // DMI driver, entered and left on a falling edge
    // ----------------------------------------------------------------------
    task automatic dmi_access(input dmi_op_e op, input logic [6:0] addr,
                              input logic [31:0] data, output dmi_rsp_t rsp,
                              output int cycles);
        dmi_req_i.addr  = addr;
        dmi_req_i.op    = op;
        dmi_req_i.data  = data;
        dmi_req_valid_i = 1'b1;
        @(negedge clk_i);
        dmi_req_valid_i = 1'b0;
        dmi_req_i.op    = DMI_NOP;
        cycles = 1;
        while (dmi_rsp_valid_o !== 1'b1) begin
            @(negedge clk_i);
            cycles++;
        end
        rsp = dmi_rsp_o;
    endtask

    function automatic logic [31:0] sbcs_word(input logic [2:0] access, input logic autoinc,
                                              input logic [2:0] err);
        logic [31:0] w;
        w = '0;
        w[SBCS_ACCESS_MSB:SBCS_ACCESS_LSB] = access;
        w[SBCS_AUTOINC_BIT] = autoinc;
        w[SBCS_ERROR_MSB:SBCS_ERROR_LSB] = err;
        return w;
    endfunction

    // Register accesses answer in one cycle
    task automatic reg_write(input string what, input logic [6:0] addr, input logic [31:0] data);
        dmi_rsp_t rsp;
        int       cycles;
        dmi_access(DMI_WRITE, addr, data, rsp, cycles);
        check_rsp(what, '{resp: DMI_OK, data: 32'h0}, rsp);
        check_latency(what, 1, cycles);
    endtask

    task automatic reg_read(input string what, input logic [6:0] addr, input logic [31:0] exp);
        dmi_rsp_t rsp;
        int       cycles;
        dmi_access(DMI_READ, addr, 32'h0, rsp, cycles);
        check_rsp(what, '{resp: DMI_OK, data: exp}, rsp);
        check_latency(what, 1, cycles);
    endtask

    // sbdata0 takes 3 cycles through the bus, 1 when blocked
    task automatic sb_write(input string what, input int exp_cycles, input logic [31:0] data);
        dmi_rsp_t rsp;
        int       cycles;
        dmi_access(DMI_WRITE, ADDR_SBDATA0, data, rsp, cycles);
        check_rsp(what, '{resp: DMI_OK, data: 32'h0}, rsp);
        check_latency(what, exp_cycles, cycles);
    endtask

    task automatic sb_read(input string what, input int exp_cycles, input logic [31:0] exp);
        dmi_rsp_t rsp;
        int       cycles;
        dmi_access(DMI_READ, ADDR_SBDATA0, 32'h0, rsp, cycles);
        check_rsp(what, '{resp: DMI_OK, data: exp}, rsp);
        check_latency(what, exp_cycles, cycles);
    endtask

    task automatic finish_test();
        tests_run++;
        if (errors == errors_at_start) begin
            tests_clean++;
            $display("%s: ok", test_name);
        end else begin
            $display("%s: %0d mismatches", test_name, errors - errors_at_start);
        end
    endtask

    // ----------------------------------------------------------------------
    // Tests
    // ----------------------------------------------------------------------
    task automatic test_registers();
        dmi_rsp_t rsp;
        int       cycles;
        test_name = "registers";
        errors_at_start = errors;
        check_word("exit after reset", 32'h0, exit_o);
        reg_write("exit write", ADDR_EXIT, 32'h0000_00A5);
        check_word("exit_o", 32'h0000_00A5, exit_o);
        reg_write("sbaddress0 write", ADDR_SBADDRESS0, 32'h1234_5678);
        reg_read("sbaddress0 read", ADDR_SBADDRESS0, 32'h1234_5678);
        dmi_access(DMI_READ, 7'h11, 32'h0, rsp, cycles);
        check_rsp("unknown address", '{resp: DMI_FAILED, data: 32'h0}, rsp);
        check_latency("unknown address", 1, cycles);
        reg_read("exit read", ADDR_EXIT, 32'h0000_00A5);
        finish_test();
    endtask

    task automatic test_word_memory();
        logic [31:0] addrs [16];
        logic [31:0] datas [16];
        logic [31:0] idx;
        test_name = "word memory";
        errors_at_start = errors;
        reg_write("sbcs word", ADDR_SBCS, sbcs_word(SBACCESS_WORD, 1'b0, 3'd0));
        // One random word from each 64-word block keeps the addresses distinct
        for (int i = 0; i < 16; i++) begin
            idx      = i * 64 + ($urandom % 64);
            addrs[i] = MEM_BASE + idx * 4;
            datas[i] = $urandom;
            reg_write("address", ADDR_SBADDRESS0, addrs[i]);
            sb_write("word write", 3, datas[i]);
        end
        for (int i = 0; i < 16; i++) begin
            reg_write("address", ADDR_SBADDRESS0, addrs[i]);
            sb_read("word read", 3, datas[i]);
        end
        finish_test();
    endtask

    task automatic test_autoinc();
        logic [31:0] base;
        base = MEM_BASE + 32'h100;
        test_name = "autoincrement";
        errors_at_start = errors;
        reg_write("sbcs autoinc", ADDR_SBCS, sbcs_word(SBACCESS_WORD, 1'b1, 3'd0));
        reg_write("base", ADDR_SBADDRESS0, base);
        for (int i = 0; i < 8; i++) begin
            sb_write("sequential write", 3, 32'hC0DE_0000 + i * 32'h0101);
        end
        reg_read("advanced address", ADDR_SBADDRESS0, base + 32);
        reg_write("base again", ADDR_SBADDRESS0, base);
        for (int i = 0; i < 8; i++) begin
            sb_read("sequential read", 3, 32'hC0DE_0000 + i * 32'h0101);
        end
        finish_test();
    endtask

    task automatic test_byte_lanes();
        logic [31:0] word_addr;
        logic [7:0]  bytes [4];
        logic [31:0] merged;
        word_addr = MEM_BASE + 32'h200;
        bytes     = '{8'h5A, 8'hC3, 8'h81, 8'hF7};
        merged    = '0;
        test_name = "byte lanes";
        errors_at_start = errors;
        reg_write("sbcs byte", ADDR_SBCS, sbcs_word(SBACCESS_BYTE, 1'b0, 3'd0));
        for (int i = 0; i < 4; i++) begin
            reg_write("byte address", ADDR_SBADDRESS0, word_addr + i);
            // Upper bits carry junk that must not reach memory
            sb_write("byte write", 3, 32'hDEAD_BE00 | bytes[i]);
            merged = merged | (32'(bytes[i]) << (8 * i));
        end
        reg_write("sbcs word", ADDR_SBCS, sbcs_word(SBACCESS_WORD, 1'b0, 3'd0));
        reg_write("word address", ADDR_SBADDRESS0, word_addr);
        sb_read("merged word", 3, merged);
        reg_write("sbcs half", ADDR_SBCS, sbcs_word(SBACCESS_HALF, 1'b0, 3'd0));
        reg_write("low half address", ADDR_SBADDRESS0, word_addr);
        sb_read("low half", 3, {16'h0, merged[15:0]});
        reg_write("high half address", ADDR_SBADDRESS0, word_addr + 2);
        sb_read("high half", 3, {16'h0, merged[31:16]});
        finish_test();
    endtask

    task automatic test_bus_errors();
        logic [31:0] inside_addr;
        logic [31:0] outside;
        inside_addr = MEM_BASE + 32'h300;
        // Aliases the inside word if the decode ignored the upper bits
        outside = inside_addr + 4 * MEM_WORDS;
        test_name = "bus errors";
        errors_at_start = errors;
        reg_write("sbcs word", ADDR_SBCS, sbcs_word(SBACCESS_WORD, 1'b0, 3'd0));
        reg_write("inside address", ADDR_SBADDRESS0, inside_addr);
        sb_write("inside write", 3, 32'h600D_F00D);
        reg_write("outside address", ADDR_SBADDRESS0, outside);
        sb_write("outside write", 3, 32'hBAD0_0001);
        reg_read("sberror set", ADDR_SBCS, sbcs_word(SBACCESS_WORD, 1'b0, SBERR_BADADDR));
        reg_write("inside address", ADDR_SBADDRESS0, inside_addr);
        sb_write("blocked write", 1, 32'hFFFF_0000);
        // sbdata0 still holds the last accepted write
        sb_read("blocked read", 1, 32'hBAD0_0001);
        reg_write("clear sberror", ADDR_SBCS, sbcs_word(SBACCESS_WORD, 1'b0, 3'h7));
        reg_read("sberror clear", ADDR_SBCS, sbcs_word(SBACCESS_WORD, 1'b0, 3'd0));
        sb_read("memory unchanged", 3, 32'h600D_F00D);
        reg_write("misaligned address", ADDR_SBADDRESS0, inside_addr + 2);
        sb_read("misaligned read", 1, 32'h600D_F00D);
        reg_read("misaligned sberror", ADDR_SBCS,
                 sbcs_word(SBACCESS_WORD, 1'b0, SBERR_BADADDR));
        reg_write("clear again", ADDR_SBCS, sbcs_word(SBACCESS_WORD, 1'b0, 3'h7));
        finish_test();
    endtask

    // Ends a run whose response never comes
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("Watchdog expired: a DMI response never arrived");
        $display("tests failed");
        $finish;
    end

    initial begin
        errors          = 0;
        tests_run       = 0;
        tests_clean     = 0;
        rst_i           = 1'b1;
        dmi_req_valid_i = 1'b0;
        dmi_req_i       = '0;
        void'($urandom(SEED));
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;
        test_registers();
        test_word_memory();
        test_autoinc();
        test_byte_lanes();
        test_bus_errors();
        $display("%0d of %0d tests clean, %0d mismatches", tests_clean, tests_run, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== verilog/soc_harness.sv ====
// ------------------------------------------------------------------------
// Debug harness top. The DMI port reaches memory through the debug
// module; exit_o follows the harness exit register.
// ------------------------------------------------------------------------

module soc_harness #(
    parameter logic [soc_pkg::BUS_AW-1:0] MEM_BASE  = 32'h8000_0000,
    parameter int unsigned                MEM_WORDS = 1024
) (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              dmi_req_valid_i,
    input  soc_pkg::dmi_req_t dmi_req_i,
    output logic              dmi_rsp_valid_o,
    output soc_pkg::dmi_rsp_t dmi_rsp_o,
    output logic [31:0]       exit_o
);
    import soc_pkg::*;

    // Debug module to decoder
    logic     dm_req_valid;
    bus_req_t dm_req;
    logic     dm_rsp_valid;
    bus_rsp_t dm_rsp;

    // Decoder to adapter
    logic     mem_req_valid;
    bus_req_t mem_req;
    logic     mem_rsp_valid;
    bus_rsp_t mem_rsp;

    // ----------------------------------------------------------------------
    // SRAM port
    // ----------------------------------------------------------------------
    logic                         sram_req;
    logic                         sram_we;
    logic [$clog2(MEM_WORDS)-1:0] sram_addr;
    logic [BUS_DW-1:0]            sram_wdata;
    logic [BUS_DW-1:0]            sram_bit_en;
    logic [BUS_DW-1:0]            sram_rdata;

    debug_module i_debug_module (
        .clk_i           ( clk_i           ),
        .rst_i           ( rst_i           ),
        .dmi_req_valid_i ( dmi_req_valid_i ),
        .dmi_req_i       ( dmi_req_i       ),
        .dmi_rsp_valid_o ( dmi_rsp_valid_o ),
        .dmi_rsp_o       ( dmi_rsp_o       ),
        .bus_req_valid_o ( dm_req_valid    ),
        .bus_req_o       ( dm_req          ),
        .bus_rsp_valid_i ( dm_rsp_valid    ),
        .bus_rsp_i       ( dm_rsp          ),
        .exit_o          ( exit_o          )
    );

    bus_decoder #(
        .MEM_BASE  ( MEM_BASE  ),
        .MEM_WORDS ( MEM_WORDS )
    ) i_bus_decoder (
        .clk_i           ( clk_i         ),
        .rst_i           ( rst_i         ),
        .req_valid_i     ( dm_req_valid  ),
        .req_i           ( dm_req        ),
        .rsp_valid_o     ( dm_rsp_valid  ),
        .rsp_o           ( dm_rsp        ),
        .mem_req_valid_o ( mem_req_valid ),
        .mem_req_o       ( mem_req       ),
        .mem_rsp_valid_i ( mem_rsp_valid ),
        .mem_rsp_i       ( mem_rsp       )
    );

    bus_to_mem #(
        .MEM_WORDS ( MEM_WORDS )
    ) i_bus_to_mem (
        .clk_i        ( clk_i         ),
        .rst_i        ( rst_i         ),
        .req_valid_i  ( mem_req_valid ),
        .req_i        ( mem_req       ),
        .rsp_valid_o  ( mem_rsp_valid ),
        .rsp_o        ( mem_rsp       ),
        .mem_req_o    ( sram_req      ),
        .mem_we_o     ( sram_we       ),
        .mem_addr_o   ( sram_addr     ),
        .mem_wdata_o  ( sram_wdata    ),
        .mem_bit_en_o ( sram_bit_en   ),
        .mem_rdata_i  ( sram_rdata    )
    );

    sram #(
        .DATA_WIDTH ( BUS_DW    ),
        .NUM_WORDS  ( MEM_WORDS )
    ) i_sram (
        .clk_i   ( clk_i       ),
        .req_i   ( sram_req    ),
        .we_i    ( sram_we     ),
        .addr_i  ( sram_addr   ),
        .wdata_i ( sram_wdata  ),
        .be_i    ( sram_bit_en ),
        .rdata_o ( sram_rdata  )
    );

endmodule

// ==== verilog/sram.sv ====
// ------------------------------------------------------------------------
// Single-port SRAM with bit-enable writes and a registered read.
// No reset, contents start undefined.
// ------------------------------------------------------------------------

module sram #(
    parameter int unsigned DATA_WIDTH = 32,
    parameter int unsigned NUM_WORDS  = 1024
) (
    input  logic                         clk_i,
    input  logic                         req_i,
    input  logic                         we_i,
    input  logic [$clog2(NUM_WORDS)-1:0] addr_i,
    input  logic [DATA_WIDTH-1:0]        wdata_i,
    input  logic [DATA_WIDTH-1:0]        be_i,
    output logic [DATA_WIDTH-1:0]        rdata_o
);

    logic [DATA_WIDTH-1:0] mem [NUM_WORDS];

    always_ff @(posedge clk_i) begin
        if (req_i) begin
            // Merge only the enabled bits
            if (we_i) begin
                mem[addr_i] <= (mem[addr_i] & ~be_i) | (wdata_i & be_i);
            end
            // Old contents are returned on a write
            rdata_o <= mem[addr_i];
        end
    end

endmodule

// ==== verilog/bus_to_mem.sv ====
// ------------------------------------------------------------------------
// Single-beat bus to SRAM adapter. Responses always come one cycle after
// the request and never carry an error.
// ------------------------------------------------------------------------

module bus_to_mem #(
    parameter int unsigned MEM_WORDS = 1024
) (
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  logic                         req_valid_i,
    input  soc_pkg::bus_req_t            req_i,
    output logic                         rsp_valid_o,
    output soc_pkg::bus_rsp_t            rsp_o,
    output logic                         mem_req_o,
    output logic                         mem_we_o,
    output logic [$clog2(MEM_WORDS)-1:0] mem_addr_o,
    output logic [soc_pkg::BUS_DW-1:0]   mem_wdata_o,
    output logic [soc_pkg::BUS_DW-1:0]   mem_bit_en_o,
    input  logic [soc_pkg::BUS_DW-1:0]   mem_rdata_i
);
    import soc_pkg::*;

    localparam int unsigned OFFSET_BITS = $clog2(BUS_DW / 8);
    localparam int unsigned INDEX_BITS  = $clog2(MEM_WORDS);

    logic rsp_pending;

    assign mem_req_o   = req_valid_i;
    assign mem_we_o    = req_i.we;
    assign mem_addr_o  = req_i.addr[INDEX_BITS+OFFSET_BITS-1:OFFSET_BITS];
    assign mem_wdata_o = req_i.wdata;

    // Byte enable to bit enable
    for (genvar i = 0; i < BUS_DW / 8; i++) begin : g_bit_en
        assign mem_bit_en_o[i*8 +: 8] = {8{req_i.be[i]}};
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rsp_pending <= 1'b0;
        end else begin
            rsp_pending <= req_valid_i;
        end
    end

    // SRAM output is valid in the cycle after the request
    always_comb begin
        rsp_valid_o = rsp_pending;
        rsp_o.rdata = mem_rdata_i;
        rsp_o.err   = 1'b0;
    end

endmodule

// ==== verilog/bus_decoder.sv ====
// ------------------------------------------------------------------------
// One-master decoder with a single memory window. MEM_BASE must be
// aligned to the window size; other addresses get an error response.
// ------------------------------------------------------------------------

module bus_decoder #(
    parameter logic [soc_pkg::BUS_AW-1:0] MEM_BASE  = 32'h8000_0000,
    parameter int unsigned                MEM_WORDS = 1024
) (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              req_valid_i,
    input  soc_pkg::bus_req_t req_i,
    output logic              rsp_valid_o,
    output soc_pkg::bus_rsp_t rsp_o,
    output logic              mem_req_valid_o,
    output soc_pkg::bus_req_t mem_req_o,
    input  logic              mem_rsp_valid_i,
    input  soc_pkg::bus_rsp_t mem_rsp_i
);
    import soc_pkg::*;

    localparam logic [BUS_AW-1:0] WIN_BYTES = MEM_WORDS * 4;

    logic [BUS_AW-1:0] offset;
    logic              in_window;
    logic              err_valid_q;

    // Unsigned offset compare also rejects addresses below the base
    assign offset    = req_i.addr - MEM_BASE;
    assign in_window = (offset < WIN_BYTES);

    assign mem_req_valid_o = req_valid_i && in_window;
    assign mem_req_o       = req_i;

    // Unmapped access answered one cycle later, like the memory
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            err_valid_q <= 1'b0;
        end else begin
            err_valid_q <= req_valid_i && !in_window;
        end
    end

    always_comb begin
        rsp_valid_o = mem_rsp_valid_i || err_valid_q;
        if (err_valid_q) begin
            rsp_o.rdata = '0;
            rsp_o.err   = 1'b1;
        end else begin
            rsp_o = mem_rsp_i;
        end
    end

    a_single_source: assert property (@(posedge clk_i) disable iff (rst_i)
        !(mem_rsp_valid_i && err_valid_q))
        else $error("Memory and error responses collide");

endmodule

// ==== verilog/debug_module.sv ====
// ------------------------------------------------------------------------
// Debug register file with a system-bus access engine. No back-pressure:
// the host must wait for each response before the next request.
// ------------------------------------------------------------------------

module debug_module (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              dmi_req_valid_i,
    input  soc_pkg::dmi_req_t dmi_req_i,
    output logic              dmi_rsp_valid_o,
    output soc_pkg::dmi_rsp_t dmi_rsp_o,
    output logic              bus_req_valid_o,
    output soc_pkg::bus_req_t bus_req_o,
    input  logic              bus_rsp_valid_i,
    input  soc_pkg::bus_rsp_t bus_rsp_i,
    output logic [31:0]       exit_o
);
    import soc_pkg::*;

    // sbcs is kept as separate fields
    logic [2:0]          sb_access;
    logic                sb_autoinc;
    logic [2:0]          sb_error;
    logic [BUS_AW-1:0]   sb_address;
    logic [BUS_DW-1:0]   sb_data;
    logic                busy;

    logic [31:0]         sbcs_value;
    logic                req_rd;
    logic                req_wr;
    logic                data_sel;
    logic                bus_start;
    logic                acc_bad;
    logic [BUS_DW/8-1:0] acc_be;
    logic [BUS_DW-1:0]   acc_wdata;
    logic [BUS_AW-1:0]   acc_incr;
    logic [BUS_DW-1:0]   rdata_shifted;
    logic [BUS_DW-1:0]   rdata_ext;
    logic                reg_known;
    logic [31:0]         reg_value;

    assign req_rd   = dmi_req_valid_i && (dmi_req_i.op == DMI_READ);
    assign req_wr   = dmi_req_valid_i && (dmi_req_i.op == DMI_WRITE);
    assign data_sel = (dmi_req_i.addr == ADDR_SBDATA0);

    // A pending error blocks every further bus access
    assign bus_start = (req_rd || req_wr) && data_sel && (sb_error == '0) && !acc_bad;

    always_comb begin
        sbcs_value = '0;
        sbcs_value[SBCS_ACCESS_MSB:SBCS_ACCESS_LSB] = sb_access;
        sbcs_value[SBCS_AUTOINC_BIT] = sb_autoinc;
        sbcs_value[SBCS_ERROR_MSB:SBCS_ERROR_LSB] = sb_error;
    end

    always_comb begin
        reg_known = 1'b1;
        reg_value = '0;
        case (dmi_req_i.addr)
            ADDR_SBCS:       reg_value = sbcs_value;
            ADDR_SBADDRESS0: reg_value = sb_address;
            ADDR_SBDATA0:    reg_value = sb_data;
            ADDR_EXIT:       reg_value = exit_o;
            default:         reg_known = 1'b0;
        endcase
    end

    // ----------------------------------------------------------------------
    // Lane selection, write replication and alignment check
    // ----------------------------------------------------------------------
    always_comb begin
        acc_bad   = 1'b0;
        acc_be    = 4'b1111;
        acc_wdata = dmi_req_i.data;
        case (sb_access)
            SBACCESS_BYTE: begin
                acc_be    = 4'b0001 << sb_address[1:0];
                acc_wdata = {4{dmi_req_i.data[7:0]}};
            end
            SBACCESS_HALF: begin
                acc_bad   = sb_address[0];
                acc_be    = 4'b0011 << sb_address[1:0];
                acc_wdata = {2{dmi_req_i.data[15:0]}};
            end
            SBACCESS_WORD: acc_bad = (sb_address[1:0] != 2'b00);
            // Sizes above a word are not supported
            default:       acc_bad = 1'b1;
        endcase
    end

    assign acc_incr = {{(BUS_AW-1){1'b0}}, 1'b1} << sb_access;

    // Read data back to bit 0, zero-extended to the access size
    always_comb begin
        rdata_shifted = bus_rsp_i.rdata >> {sb_address[1:0], 3'b000};
        case (sb_access)
            SBACCESS_BYTE: rdata_ext = {24'b0, rdata_shifted[7:0]};
            SBACCESS_HALF: rdata_ext = {16'b0, rdata_shifted[15:0]};
            default:       rdata_ext = rdata_shifted;
        endcase
    end

    // ----------------------------------------------------------------------
    // Control state and registers
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            dmi_rsp_valid_o <= 1'b0;
            bus_req_valid_o <= 1'b0;
            busy            <= 1'b0;
            sb_access       <= '0;
            sb_autoinc      <= 1'b0;
            sb_error        <= '0;
            sb_address      <= '0;
            sb_data         <= '0;
            exit_o          <= '0;
        end else begin
            dmi_rsp_valid_o <= 1'b0;
            bus_req_valid_o <= 1'b0;
            if (req_rd || req_wr) begin
                if (bus_start) begin
                    bus_req_valid_o <= 1'b1;
                    busy            <= 1'b1;
                end else begin
                    dmi_rsp_valid_o <= 1'b1;
                end
                if (data_sel && (sb_error == '0) && acc_bad) begin
                    sb_error <= SBERR_BADADDR;
                end
                if (req_wr) begin
                    case (dmi_req_i.addr)
                        ADDR_SBCS: begin
                            sb_access  <= dmi_req_i.data[SBCS_ACCESS_MSB:SBCS_ACCESS_LSB];
                            sb_autoinc <= dmi_req_i.data[SBCS_AUTOINC_BIT];
                            // Write 1 to clear
                            sb_error   <= sb_error &
                                          ~dmi_req_i.data[SBCS_ERROR_MSB:SBCS_ERROR_LSB];
                        end
                        ADDR_SBADDRESS0: sb_address <= dmi_req_i.data;
                        ADDR_SBDATA0: begin
                            if (bus_start) begin
                                sb_data <= dmi_req_i.data;
                            end
                        end
                        ADDR_EXIT: exit_o <= dmi_req_i.data;
                        default: ;
                    endcase
                end
            end
            if (busy && bus_rsp_valid_i) begin
                busy            <= 1'b0;
                dmi_rsp_valid_o <= 1'b1;
                if (bus_rsp_i.err) begin
                    sb_error <= SBERR_BADADDR;
                end else begin
                    if (!bus_req_o.we) begin
                        sb_data <= rdata_ext;
                    end
                    if (sb_autoinc) begin
                        sb_address <= sb_address + acc_incr;
                    end
                end
            end
        end
    end

    // Payload registers, qualified by their strobes
    always_ff @(posedge clk_i) begin
        if (bus_start) begin
            bus_req_o.we    <= req_wr;
            bus_req_o.addr  <= sb_address;
            bus_req_o.be    <= acc_be;
            bus_req_o.wdata <= acc_wdata;
        end
        if (busy && bus_rsp_valid_i) begin
            dmi_rsp_o.resp <= DMI_OK;
            if (bus_req_o.we) begin
                dmi_rsp_o.data <= '0;
            end else if (bus_rsp_i.err) begin
                dmi_rsp_o.data <= sb_data;
            end else begin
                dmi_rsp_o.data <= rdata_ext;
            end
        end else if ((req_rd || req_wr) && !bus_start) begin
            if (reg_known) begin
                dmi_rsp_o.resp <= DMI_OK;
            end else begin
                dmi_rsp_o.resp <= DMI_FAILED;
            end
            dmi_rsp_o.data <= req_rd ? reg_value : '0;
        end
    end

    // Host must not issue a request while a bus access is in flight
    a_no_req_while_busy: assert property (@(posedge clk_i) disable iff (rst_i)
        busy |-> !(dmi_req_valid_i && (dmi_req_i.op != DMI_NOP)))
        else $error("DMI request while bus access pending");

    a_rsp_has_req: assert property (@(posedge clk_i) disable iff (rst_i)
        bus_rsp_valid_i |-> busy)
        else $error("Bus response without a pending request");

endmodule

// ==== verilog/soc_pkg.sv ====
// ------------------------------------------------------------------------
// Bus and debug transport types for the debug harness. Bus widths are
// fixed at 32 bits and the access logic assumes four byte lanes.
// ------------------------------------------------------------------------

package soc_pkg;

    localparam int BUS_AW = 32;
    localparam int BUS_DW = 32;

    // DMI operation and response codes
    typedef enum logic [1:0] {
        DMI_NOP   = 2'd0,
        DMI_READ  = 2'd1,
        DMI_WRITE = 2'd2
    } dmi_op_e;

    typedef enum logic [1:0] {
        DMI_OK     = 2'd0,
        DMI_FAILED = 2'd2
    } dmi_resp_e;

    typedef struct packed {
        logic [6:0]  addr;
        dmi_op_e     op;
        logic [31:0] data;
    } dmi_req_t;

    typedef struct packed {
        dmi_resp_e   resp;
        logic [31:0] data;
    } dmi_rsp_t;

    // Single-beat system bus
    typedef struct packed {
        logic                  we;
        logic [BUS_AW-1:0]     addr;
        logic [BUS_DW/8-1:0]   be;
        logic [BUS_DW-1:0]     wdata;
    } bus_req_t;

    typedef struct packed {
        logic [BUS_DW-1:0] rdata;
        logic              err;
    } bus_rsp_t;

    // Debug register map
    localparam logic [6:0] ADDR_SBCS       = 7'h38;
    localparam logic [6:0] ADDR_SBADDRESS0 = 7'h39;
    localparam logic [6:0] ADDR_SBDATA0    = 7'h3C;
    localparam logic [6:0] ADDR_EXIT       = 7'h70;

    // sbcs fields
    localparam int SBCS_AUTOINC_BIT = 16;
    localparam int SBCS_ACCESS_LSB  = 17;
    localparam int SBCS_ACCESS_MSB  = 19;
    localparam int SBCS_ERROR_LSB   = 12;
    localparam int SBCS_ERROR_MSB   = 14;

    localparam logic [2:0] SBACCESS_BYTE = 3'd0;
    localparam logic [2:0] SBACCESS_HALF = 3'd1;
    localparam logic [2:0] SBACCESS_WORD = 3'd2;

    localparam logic [2:0] SBERR_BADADDR = 3'd2;

endpackage
